/* common/rv_exec_macros.svh */
`ifndef RV_EXEC_MACROS_SVH
`define RV_EXEC_MACROS_SVH

// Datapath and register index widths
`define RV_XLEN   32
`define RV_REG_AW 5

// Wishbone word address width
`define RV_WB_AW  6

// Word address map
`define RV_ADDR_INSTR    6'd0
// Bit 0 zero, bit 1 illegal
`define RV_ADDR_STATUS   6'd1
// Register i sits at base + i
`define RV_ADDR_REG_BASE 6'd32

`endif

/* common/rv_exec_pkg.sv */
package rv_exec_pkg;

  // ALU operation select
  typedef enum logic [4:0] {
    ALU_IMM   = 5'd0,
    ALU_ADD   = 5'd1,
    ALU_SUB   = 5'd2,
    ALU_AND   = 5'd3,
    ALU_XOR   = 5'd4,
    ALU_OR    = 5'd5,
    ALU_SL    = 5'd6,
    ALU_SR    = 5'd7,
    ALU_DIV   = 5'd8,
    ALU_SSR   = 5'd9,
    ALU_SLES  = 5'd10,
    ALU_ULES  = 5'd11,
    ALU_REMU  = 5'd12,
    ALU_MUL   = 5'd13,
    ALU_DIVU  = 5'd14,
    ALU_REM   = 5'd15,
    // 16 is unused here
    ALU_MULHU = 5'd17
  } alu_op_e;

  // Major opcode, instr[6:0]
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111
  } rv_opcode_e;

endpackage

/* exu/exu.sv */
`timescale 1ns/100ps
`include "rv_exec_macros.svh"

module exu (
  input  logic [`RV_XLEN-1:0]  src1,
  input  logic [`RV_XLEN-1:0]  src2,
  input  rv_exec_pkg::alu_op_e alu_op,
  output logic [`RV_XLEN-1:0]  result,
  output logic                 zero
);

  import rv_exec_pkg::*;

  localparam logic [`RV_XLEN-1:0] INT_MIN = {1'b1, {(`RV_XLEN-1){1'b0}}};

  logic [4:0]                 shamt;
  logic                       div_zero;
  logic                       div_ovf;
  logic [`RV_XLEN-1:0]        sdivisor;
  logic [`RV_XLEN-1:0]        udivisor;
  logic signed [`RV_XLEN-1:0] quot_s;
  logic signed [`RV_XLEN-1:0] rem_s;
  logic [`RV_XLEN-1:0]        quot_u;
  logic [`RV_XLEN-1:0]        rem_u;
  logic signed [`RV_XLEN-1:0] sra_res;
  logic [2*`RV_XLEN-1:0]      prod;

  assign shamt = src2[4:0];

  // RISC-V division corner cases
  assign div_zero = (src2 == '0);
  assign div_ovf  = (src1 == INT_MIN) && (src2 == '1);

  // Divide by one on overflow gives dividend and zero remainder for free
  assign sdivisor = (div_zero || div_ovf) ? {{(`RV_XLEN-1){1'b0}}, 1'b1} : src2;
  assign udivisor = div_zero ? {{(`RV_XLEN-1){1'b0}}, 1'b1} : src2;

  assign quot_s = $signed(src1) / $signed(sdivisor);
  assign rem_s  = $signed(src1) % $signed(sdivisor);
  assign quot_u = src1 / udivisor;
  assign rem_u  = src1 % udivisor;

  assign sra_res = $signed(src1) >>> shamt;

  // Unsigned product, low half serves MUL as well
  assign prod = {{`RV_XLEN{1'b0}}, src1} * {{`RV_XLEN{1'b0}}, src2};

  always_comb begin
    case (alu_op)
      ALU_IMM:   result = src2;
      ALU_ADD:   result = src1 + src2;
      ALU_SUB:   result = src1 - src2;
      ALU_AND:   result = src1 & src2;
      ALU_XOR:   result = src1 ^ src2;
      ALU_OR:    result = src1 | src2;
      ALU_SL:    result = src1 << shamt;
      ALU_SR:    result = src1 >> shamt;
      ALU_SSR:   result = sra_res;
      ALU_SLES:  result = {{(`RV_XLEN-1){1'b0}}, ($signed(src1) < $signed(src2))};
      ALU_ULES:  result = {{(`RV_XLEN-1){1'b0}}, (src1 < src2)};
      ALU_MUL:   result = prod[`RV_XLEN-1:0];
      ALU_MULHU: result = prod[2*`RV_XLEN-1:`RV_XLEN];
      ALU_DIV:   result = div_zero ? '1 : quot_s;
      ALU_DIVU:  result = div_zero ? '1 : quot_u;
      ALU_REM:   result = div_zero ? src1 : rem_s;
      ALU_REMU:  result = div_zero ? src1 : rem_u;
      default:   result = '0;
    endcase
  end

  // Flag only meaningful for add and subtract
  assign zero = ((alu_op == ALU_ADD) || (alu_op == ALU_SUB)) && (result == '0);

  always_comb begin
    if (zero) begin
      zero_operands_a: assert final (
        ((alu_op == ALU_ADD) && (src1 == -src2)) ||
        ((alu_op == ALU_SUB) && (src1 == src2)))
        else $error("exu: zero set with op %0d src1 %h src2 %h", alu_op, src1, src2);
    end
  end

endmodule

/* rtl/idu.sv */
`timescale 1ns/100ps
`include "rv_exec_macros.svh"

module idu (
  input  logic [`RV_XLEN-1:0]   instr,
  output logic [`RV_REG_AW-1:0] rs1,
  output logic [`RV_REG_AW-1:0] rs2,
  output logic [`RV_REG_AW-1:0] rd,
  output rv_exec_pkg::alu_op_e  alu_op,
  output logic [`RV_XLEN-1:0]   imm,
  output logic                  use_imm,
  output logic                  legal
);

  import rv_exec_pkg::*;

  rv_opcode_e          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_u;

  assign opcode = rv_opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign rd  = instr[11:7];
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];

  assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'b0};

  always_comb begin
    alu_op  = ALU_ADD;
    imm     = imm_i;
    use_imm = 1'b0;
    legal   = 1'b1;
    case (opcode)
      OPC_LUI: begin
        alu_op  = ALU_IMM;
        imm     = imm_u;
        use_imm = 1'b1;
      end
      OPC_OP_IMM: begin
        use_imm = 1'b1;
        case (funct3)
          3'b000: alu_op = ALU_ADD;
          3'b010: alu_op = ALU_SLES;
          3'b011: alu_op = ALU_ULES;
          3'b100: alu_op = ALU_XOR;
          3'b110: alu_op = ALU_OR;
          3'b111: alu_op = ALU_AND;
          3'b001: begin
            alu_op = ALU_SL;
            legal  = (funct7 == 7'b0000000);
          end
          // Bit 30 picks arithmetic shift
          default: begin
            alu_op = instr[30] ? ALU_SSR : ALU_SR;
            legal  = (funct7 == {1'b0, instr[30], 5'b00000});
          end
        endcase
      end
      OPC_OP: begin
        case (funct7)
          7'b0000000: begin
            case (funct3)
              3'b000: alu_op = ALU_ADD;
              3'b001: alu_op = ALU_SL;
              3'b010: alu_op = ALU_SLES;
              3'b011: alu_op = ALU_ULES;
              3'b100: alu_op = ALU_XOR;
              3'b101: alu_op = ALU_SR;
              3'b110: alu_op = ALU_OR;
              default: alu_op = ALU_AND;
            endcase
          end
          7'b0100000: begin
            case (funct3)
              3'b000: alu_op = ALU_SUB;
              3'b101: alu_op = ALU_SSR;
              default: legal = 1'b0;
            endcase
          end
          // M extension, MULH and MULHSU not supported
          7'b0000001: begin
            case (funct3)
              3'b000: alu_op = ALU_MUL;
              3'b011: alu_op = ALU_MULHU;
              3'b100: alu_op = ALU_DIV;
              3'b101: alu_op = ALU_DIVU;
              3'b110: alu_op = ALU_REM;
              3'b111: alu_op = ALU_REMU;
              default: legal = 1'b0;
            endcase
          end
          default: legal = 1'b0;
        endcase
      end
      default: legal = 1'b0;
    endcase
  end

endmodule

/* rtl/regfile.sv */
`timescale 1ns/100ps
`include "rv_exec_macros.svh"

module regfile (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`RV_REG_AW-1:0] rs1,
  input  logic [`RV_REG_AW-1:0] rs2,
  input  logic [`RV_REG_AW-1:0] raddr3,
  input  logic [`RV_REG_AW-1:0] rd,
  input  logic [`RV_XLEN-1:0]   wdata,
  input  logic                  wen,
  output logic [`RV_XLEN-1:0]   rdata1,
  output logic [`RV_XLEN-1:0]   rdata2,
  output logic [`RV_XLEN-1:0]   rdata3
);

  localparam int NREGS = 1 << `RV_REG_AW;

  logic [`RV_XLEN-1:0] regs [0:NREGS-1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

  // Two operand ports plus one for bus reads
  assign rdata1 = regs[rs1];
  assign rdata2 = regs[rs2];
  assign rdata3 = regs[raddr3];

  x0_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    (wen && (rd == '0)) |=> (regs[0] == '0))
    else $error("regfile: x0 changed to %h", regs[0]);

endmodule

/* rtl/rv_exec_top.sv */
`timescale 1ns/100ps
`include "rv_exec_macros.svh"

module rv_exec_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  logic [`RV_WB_AW-1:0] wb_adr,
  input  logic [`RV_XLEN-1:0]  wb_dat_w,
  output logic [`RV_XLEN-1:0]  wb_dat_r,
  output logic                 wb_ack
);

  import rv_exec_pkg::*;

  logic [`RV_XLEN-1:0]   instr;
  logic [`RV_REG_AW-1:0] rs1;
  logic [`RV_REG_AW-1:0] rs2;
  logic [`RV_REG_AW-1:0] rd;
  alu_op_e               alu_op;
  logic [`RV_XLEN-1:0]   imm;
  logic                  use_imm;
  logic                  legal;
  logic [`RV_XLEN-1:0]   rdata1;
  logic [`RV_XLEN-1:0]   rdata2;
  logic [`RV_XLEN-1:0]   rdata3;
  logic [`RV_XLEN-1:0]   src1;
  logic [`RV_XLEN-1:0]   src2;
  logic [`RV_XLEN-1:0]   result;
  logic                  zero;
  logic [`RV_REG_AW-1:0] rf_raddr;
  logic                  rf_wen;

  wb_exec_ctrl u_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .instr    (instr),
    .src1     (src1),
    .src2     (src2),
    .rf_raddr (rf_raddr),
    .rf_wen   (rf_wen),
    .rdata1   (rdata1),
    .rdata2   (rdata2),
    .rdata3   (rdata3),
    .imm      (imm),
    .use_imm  (use_imm),
    .legal    (legal),
    .result   (result),
    .zero     (zero)
  );

  idu u_idu (
    .instr   (instr),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (rd),
    .alu_op  (alu_op),
    .imm     (imm),
    .use_imm (use_imm),
    .legal   (legal)
  );

  regfile u_rf (
    .clk    (clk),
    .rst_n  (rst_n),
    .rs1    (rs1),
    .rs2    (rs2),
    .raddr3 (rf_raddr),
    .rd     (rd),
    .wdata  (result),
    .wen    (rf_wen),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .rdata3 (rdata3)
  );

  exu u_exu (
    .src1   (src1),
    .src2   (src2),
    .alu_op (alu_op),
    .result (result),
    .zero   (zero)
  );

endmodule

/* rtl/wb_exec_ctrl.sv */
`timescale 1ns/100ps
`include "rv_exec_macros.svh"

module wb_exec_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [`RV_WB_AW-1:0]  wb_adr,
  input  logic [`RV_XLEN-1:0]   wb_dat_w,
  output logic [`RV_XLEN-1:0]   wb_dat_r,
  output logic                  wb_ack,
  output logic [`RV_XLEN-1:0]   instr,
  output logic [`RV_XLEN-1:0]   src1,
  output logic [`RV_XLEN-1:0]   src2,
  output logic [`RV_REG_AW-1:0] rf_raddr,
  output logic                  rf_wen,
  input  logic [`RV_XLEN-1:0]   rdata1,
  input  logic [`RV_XLEN-1:0]   rdata2,
  input  logic [`RV_XLEN-1:0]   rdata3,
  input  logic [`RV_XLEN-1:0]   imm,
  input  logic                  use_imm,
  input  logic                  legal,
  input  logic [`RV_XLEN-1:0]   result,
  input  logic                  zero
);

  logic                 req;
  logic                 instr_wr;
  logic                 reg_hit;
  logic [`RV_WB_AW-1:0] reg_off;
  logic                 status_zero;
  logic                 status_illegal;
  logic [`RV_XLEN-1:0]  rd_data;

  // Masked during ack so a held strobe is not taken twice
  assign req      = wb_cyc && wb_stb && !wb_ack;
  assign instr_wr = req && wb_we && (wb_adr == `RV_ADDR_INSTR);

  assign reg_hit  = (wb_adr >= `RV_ADDR_REG_BASE);
  assign reg_off  = wb_adr - `RV_ADDR_REG_BASE;
  assign rf_raddr = reg_off[`RV_REG_AW-1:0];

  // Decode and execute run in the request cycle
  assign instr  = instr_wr ? wb_dat_w : '0;
  assign src1   = rdata1;
  assign src2   = use_imm ? imm : rdata2;
  assign rf_wen = instr_wr && legal;

  always_comb begin
    if (wb_adr == `RV_ADDR_STATUS) begin
      rd_data = {{(`RV_XLEN-2){1'b0}}, status_illegal, status_zero};
    end else if (reg_hit) begin
      rd_data = rdata3;
    end else begin
      rd_data = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_ack         <= 1'b0;
      status_zero    <= 1'b0;
      status_illegal <= 1'b0;
    end else begin
      wb_ack <= req;
      if (instr_wr) begin
        status_zero    <= legal && zero;
        status_illegal <= !legal;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req && !wb_we) begin
      wb_dat_r <= rd_data;
    end
  end

  ack_after_req_a: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
    else $error("wb_exec_ctrl: ack without a request");

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the rv_exec testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
  --timescale 1ns/100ps \
  --top-module tb_rv_exec \
  --Mdir "$OBJ" -o tb_rv_exec \
  -f rv_exec.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/tb_rv_exec" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

# Verdict comes from the log
if grep -q "Test FAILED" "$LOG"; then
  exit 1
fi
exit 0

/* rv_exec.f */
+incdir+common
+incdir+testbench
common/rv_exec_pkg.sv
exu/exu.sv
rtl/idu.sv
rtl/regfile.sv
rtl/wb_exec_ctrl.sv
rtl/rv_exec_top.sv
testbench/tb_rv_exec.sv

/* testbench/tb_rv_exec_table.svh */
// Columns: instruction word, rd, expected rd value, zero flag, illegal flag
task automatic load_rows();
  // Operands
  add_row(lui_word(1, 'h12345), 1, 32'h12345000, 0, 0);
  add_row(i_type(0, 1, 1, 'h678), 1, 32'h12345678, 0, 0);
  add_row(i_type(0, 2, 0, 'hFFF), 2, 32'hFFFFFFFF, 0, 0);
  add_row(lui_word(3, 'h80000), 3, 32'h80000000, 0, 0);
  add_row(i_type(0, 4, 0, 7), 4, 32'h00000007, 0, 0);
  add_row(i_type(0, 5, 0, 'hFF9), 5, 32'hFFFFFFF9, 0, 0);
  add_row(i_type(0, 6, 0, 'h7FF), 6, 32'h000007FF, 0, 0);
  // Register arithmetic and logic
  add_row(r_type(0, 0, 7, 1, 6), 7, 32'h12345E77, 0, 0);
  add_row(r_type('h20, 0, 8, 1, 1), 8, 32'h00000000, 1, 0);
  add_row(r_type('h20, 0, 9, 4, 5), 9, 32'h0000000E, 0, 0);
  add_row(r_type(0, 0, 10, 2, 2), 10, 32'hFFFFFFFE, 0, 0);
  add_row(r_type(0, 0, 11, 4, 5), 11, 32'h00000000, 1, 0);
  add_row(r_type(0, 7, 12, 3, 6), 12, 32'h00000000, 0, 0);
  add_row(r_type(0, 6, 13, 3, 6), 13, 32'h800007FF, 0, 0);
  add_row(r_type(0, 4, 14, 1, 2), 14, 32'hEDCBA987, 0, 0);
  add_row(i_type(7, 15, 1, 'h0F0), 15, 32'h00000070, 0, 0);
  add_row(i_type(6, 16, 3, 'h00F), 16, 32'h8000000F, 0, 0);
  add_row(i_type(4, 17, 1, 'hFFF), 17, 32'hEDCBA987, 0, 0);
  // Shift amount 36 uses only its low five bits
  add_row(i_type(0, 18, 0, 36), 18, 32'h00000024, 0, 0);
  add_row(r_type(0, 1, 19, 1, 18), 19, 32'h23456780, 0, 0);
  add_row(r_type(0, 5, 20, 3, 18), 20, 32'h08000000, 0, 0);
  add_row(r_type('h20, 5, 21, 3, 18), 21, 32'hF8000000, 0, 0);
  add_row(i_type(1, 22, 1, 8), 22, 32'h34567800, 0, 0);
  add_row(i_type(5, 23, 2, 28), 23, 32'h0000000F, 0, 0);
  add_row(i_type(5, 24, 3, 'h41F), 24, 32'hFFFFFFFF, 0, 0);
  // Compares
  add_row(r_type(0, 2, 25, 3, 4), 25, 32'h00000001, 0, 0);
  add_row(r_type(0, 3, 26, 3, 4), 26, 32'h00000000, 0, 0);
  add_row(i_type(2, 27, 5, 0), 27, 32'h00000001, 0, 0);
  add_row(i_type(3, 28, 4, 'hFFF), 28, 32'h00000001, 0, 0);
  // Multiply and divide
  add_row(r_type(1, 0, 29, 1, 4), 29, 32'h7F6E5D48, 0, 0);
  add_row(r_type(1, 3, 30, 2, 2), 30, 32'hFFFFFFFE, 0, 0);
  add_row(r_type(1, 0, 31, 2, 2), 31, 32'h00000001, 0, 0);
  add_row(i_type(0, 10, 0, 2), 10, 32'h00000002, 0, 0);
  add_row(r_type(1, 4, 11, 5, 10), 11, 32'hFFFFFFFD, 0, 0);
  add_row(r_type(1, 6, 12, 5, 10), 12, 32'hFFFFFFFF, 0, 0);
  add_row(r_type(1, 5, 13, 5, 10), 13, 32'h7FFFFFFC, 0, 0);
  add_row(r_type(1, 7, 14, 5, 10), 14, 32'h00000001, 0, 0);
  add_row(r_type(1, 4, 15, 4, 0), 15, 32'hFFFFFFFF, 0, 0);
  add_row(r_type(1, 5, 16, 4, 0), 16, 32'hFFFFFFFF, 0, 0);
  add_row(r_type(1, 6, 17, 4, 0), 17, 32'h00000007, 0, 0);
  add_row(r_type(1, 7, 18, 5, 0), 18, 32'hFFFFFFF9, 0, 0);
  add_row(r_type(1, 4, 19, 3, 2), 19, 32'h80000000, 0, 0);
  add_row(r_type(1, 6, 20, 3, 2), 20, 32'h00000000, 0, 0);
  add_row(r_type(1, 5, 21, 3, 2), 21, 32'h00000000, 0, 0);
  // x0 target, then a store word and MULH which both must be rejected
  add_row(i_type(0, 0, 4, 5), 0, 32'h00000000, 0, 0);
  add_row(32'h0021A0A3, 1, 32'h12345678, 0, 1);
  add_row(r_type(1, 1, 4, 1, 2), 4, 32'h00000007, 0, 1);
  add_row(i_type(0, 21, 0, 'h55), 21, 32'h00000055, 0, 0);
endtask

/* testbench/tb_rv_exec.sv */
`timescale 1ns/100ps
`include "rv_exec_macros.svh"

module tb_rv_exec;

  localparam int ACK_WAIT        = 8;
  localparam int TRANSFER_CYCLES = 4;
  localparam int SETUP_TRANSFERS = 48;
  localparam int RAND_ROUNDS     = 8;

  typedef struct packed {
    logic [`RV_XLEN-1:0]   instr;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   value;
    logic                  zero;
    logic                  illegal;
  } row_t;

  logic                 clk;
  logic                 rst_n;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  logic [`RV_WB_AW-1:0] wb_adr;
  logic [`RV_XLEN-1:0]  wb_dat_w;
  logic [`RV_XLEN-1:0]  wb_dat_r;
  logic                 wb_ack;

  row_t rows[$];
  int   errors;
  int   checks;
  int   seed;
  int   cycle_limit;
  int   cycle_count = 0;

  rv_exec_top UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: run stopped after %0d cycles", cycle_count);
      $display("Test FAILED");
      $finish;
    end
  end

  // RV32 instruction encoders
  function automatic logic [31:0] r_type(input int f7, input int f3, input int rd,
                                         input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input int f3, input int rd, input int rs1,
                                         input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
  endfunction

  function automatic logic [31:0] lui_word(input int rd, input int imm);
    return {imm[19:0], rd[4:0], 7'b0110111};
  endfunction

  function automatic int sext12(input int v);
    return (v >= 'h800) ? v - 'h1000 : v;
  endfunction

  task automatic add_row(input logic [31:0] instr, input int rd, input logic [31:0] value,
                         input int zero, input int illegal);
    row_t r;
    r.instr   = instr;
    r.rd      = rd[4:0];
    r.value   = value;
    r.zero    = zero[0];
    r.illegal = illegal[0];
    rows.push_back(r);
  endtask

  // ADDI operands from random immediates, then ADD and XOR of them
  task automatic add_random_rows();
    int rnd;
    int val_a;
    int val_b;
    int sum;
    for (int k = 0; k < RAND_ROUNDS; k++) begin
      rnd   = $random(seed);
      val_a = sext12(rnd & 'hFFF);
      rnd   = $random(seed);
      val_b = sext12(rnd & 'hFFF);
      sum   = val_a + val_b;
      add_row(i_type(0, 26, 0, val_a), 26, val_a, (val_a == 0) ? 1 : 0, 0);
      add_row(i_type(0, 27, 0, val_b), 27, val_b, (val_b == 0) ? 1 : 0, 0);
      add_row(r_type(0, 0, 28, 26, 27), 28, sum, (sum == 0) ? 1 : 0, 0);
      add_row(r_type(0, 4, 29, 26, 27), 29, val_a ^ val_b, 0, 0);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    value_match_a: assert (got === exp) else begin
      errors++;
      $display("Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // Wait for ack, release the bus, then ack must be gone a cycle later
  task automatic finish_transfer(input logic [`RV_WB_AW-1:0] adr,
                                 output logic [`RV_XLEN-1:0] data);
    int   waited;
    logic acked;
    waited = 0;
    acked  = 1'b0;
    while (!acked && waited < ACK_WAIT) begin
      @(negedge clk);
      waited++;
      acked = wb_ack;
    end
    data   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    ack_seen_a: assert (acked) else begin
      errors++;
      $display("No acknowledge within %0d cycles for address %h", ACK_WAIT, adr);
    end
    if (acked) begin
      @(negedge clk);
      check_value("wb_ack", {31'b0, wb_ack}, '0);
    end
  endtask

  task automatic wb_write(input logic [`RV_WB_AW-1:0] adr, input logic [`RV_XLEN-1:0] data);
    logic [`RV_XLEN-1:0] ignored;
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    finish_transfer(adr, ignored);
  endtask

  task automatic wb_read(input logic [`RV_WB_AW-1:0] adr, output logic [`RV_XLEN-1:0] data);
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    finish_transfer(adr, data);
  endtask

  task automatic expect_read(input logic [`RV_WB_AW-1:0] adr, input logic [`RV_XLEN-1:0] exp,
                             input string name);
    logic [`RV_XLEN-1:0] data;
    wb_read(adr, data);
    check_value(name, data, exp);
  endtask

  task automatic check_reset_state();
    expect_read(`RV_ADDR_STATUS, '0, "status after reset");
    for (int r = 0; r < 32; r++) begin
      expect_read(`RV_ADDR_REG_BASE + 6'(r), '0, $sformatf("x%0d after reset", r));
    end
  endtask

  // Registers and status hold nonzero values here, so aliasing shows up
  task automatic check_address_map();
    wb_write(`RV_ADDR_INSTR, 32'h00000000);
    expect_read(`RV_ADDR_STATUS, 32'h00000002, "status after illegal word");
    // Instruction register is write only
    expect_read(`RV_ADDR_INSTR, '0, "read of address 00");
    expect_read(6'd2, '0, "read of address 02");
    expect_read(6'd17, '0, "read of address 11");
    expect_read(6'd31, '0, "read of address 1f");
    wb_write(`RV_ADDR_STATUS, 32'hFFFFFFFF);
    expect_read(`RV_ADDR_STATUS, 32'h00000002, "status after write");
  endtask

  `include "tb_rv_exec_table.svh"

  initial begin
    row_t row;
    clk      = 1'b0;
    rst_n    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    errors   = 0;
    checks   = 0;
    seed     = 38690;
    load_rows();
    add_random_rows();
    cycle_limit = (SETUP_TRANSFERS + 3 * rows.size()) * TRANSFER_CYCLES + 16;

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_value("wb_ack", {31'b0, wb_ack}, '0);
    check_reset_state();

    for (int i = 0; i < rows.size(); i++) begin
      row = rows[i];
      wb_write(`RV_ADDR_INSTR, row.instr);
      expect_read(`RV_ADDR_STATUS, {{(`RV_XLEN-2){1'b0}}, row.illegal, row.zero},
                  $sformatf("status (row %0d)", i));
      expect_read(`RV_ADDR_REG_BASE + {1'b0, row.rd}, row.value,
                  $sformatf("x%0d (row %0d)", row.rd, i));
    end

    check_address_map();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
